/* filelist.f */
+incdir+design
design/avr_periph_pkg.sv
design/tim_prescaler.sv
design/tim0_8bit.sv
design/gpio_port.sv
design/avr_periph_top.sv
verif/avr_periph_chk.sv
verif/tb_avr_periph.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_avr_periph \
    -f filelist.f -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vtb_avr_periph > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed"
exit 0

/* verif/tb_avr_periph.sv */
/* Directed testbench standing in for the core on both buses.
   Inputs change 1 ns after the rising edge; reads sample mid-cycle. */
`timescale 1ns/1ps
`include "avr_periph_macros.svh"

module tb_avr_periph;
    import avr_periph_pkg::*;

    localparam logic [31:0] SEED = 32'hbea5_5e22;

    logic       clk;
    logic       rst;
    io_addr_t   io_addr;
    logic       io_wr;
    logic       io_rd;
    byte_t      io_wdata;
    byte_t      io_rdata;
    data_addr_t data_addr;
    logic       data_wr;
    logic       data_rd;
    byte_t      data_wdata;
    byte_t      data_rdata;
    irq_vec_t   irq;
    irq_vec_t   irq_ack;
    logic       oc0a;
    logic       oc0a_en;
    byte_t      pb_in;
    byte_t      pb_out;
    byte_t      pb_oe;
    int         errors;

    avr_periph_top i_avr_periph_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic io_write(input io_addr_t addr, input byte_t wdata);
        io_addr  = addr;
        io_wdata = wdata;
        io_wr    = 1'b1;
        @(posedge clk);
        #1;
        io_wr = 1'b0;
    endtask

    task automatic io_read(input io_addr_t addr, output byte_t rdata);
        io_addr = addr;
        io_rd   = 1'b1;
        #2;
        rdata = io_rdata;
        @(posedge clk);
        #1;
        io_rd = 1'b0;
    endtask

    task automatic data_write(input data_addr_t addr, input byte_t wdata);
        data_addr  = addr;
        data_wdata = wdata;
        data_wr    = 1'b1;
        @(posedge clk);
        #1;
        data_wr = 1'b0;
    endtask

    task automatic data_read(input data_addr_t addr, output byte_t rdata);
        data_addr = addr;
        data_rd   = 1'b1;
        #2;
        rdata = data_rdata;
        @(posedge clk);
        #1;
        data_rd = 1'b0;
    endtask

    function automatic byte_t rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    task automatic report_mismatch(input string name, input byte_t exp, input byte_t act);
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic log_error(input string what);
        errors++;
        $display("ERROR %s", what);
    endtask

    // Random write and readback of the stored bits only
    task automatic io_readback(input string name, input io_addr_t addr, input byte_t keep);
        byte_t v;
        byte_t got;
        v = rand_byte();
        io_write(addr, v);
        io_read(addr, got);
        if (got !== (v & keep))
            report_mismatch(name, v & keep, got);
    endtask

    task automatic register_access();
        byte_t v;
        byte_t got;
        io_readback("reg_access OCR0A", `OCR0A_ADDR, 8'hFF);
        io_readback("reg_access OCR0B", `OCR0B_ADDR, 8'hFF);
        // COM0A in bits 7:6 and WGM01:0 in bits 1:0
        io_readback("reg_access TCCR0A", `TCCR0A_ADDR, 8'hC3);
        io_readback("reg_access DDRB", `PORTB_DDR_ADDR, `PORTB_PIN_MASK);
        io_readback("reg_access PORTB", `PORTB_PORT_ADDR, `PORTB_PIN_MASK);
        v = rand_byte();
        data_write(`TIMSK0_ADDR, v);
        data_read(`TIMSK0_ADDR, got);
        if (got !== (v & 8'h07))
            report_mismatch("reg_access TIMSK0", v & 8'h07, got);
        io_read(6'h3F, got);
        if (got !== 8'h00)
            report_mismatch("reg_access unmapped io", 8'h00, got);
        data_read(8'h20, got);
        if (got !== 8'h00)
            report_mismatch("reg_access unmapped data", 8'h00, got);
        io_write(`TCCR0A_ADDR, 8'h00);
        io_write(`PORTB_PORT_ADDR, 8'h00);
        io_write(`PORTB_DDR_ADDR, 8'h00);
        data_write(`TIMSK0_ADDR, 8'h00);
    endtask

    task automatic gpio_pins();
        byte_t got;
        int    waited;
        io_write(`PORTB_PORT_ADDR, 8'hA5);
        io_write(`PORTB_DDR_ADDR, 8'h3C);
        if (pb_out !== (8'hA5 & `PORTB_PIN_MASK))
            report_mismatch("gpio pb_out", 8'hA5 & `PORTB_PIN_MASK, pb_out);
        if (pb_oe !== (8'h3C & `PORTB_PIN_MASK))
            report_mismatch("gpio pb_oe", 8'h3C & `PORTB_PIN_MASK, pb_oe);
        io_write(`PORTB_PIN_ADDR, 8'hFF);
        io_read(`PORTB_PORT_ADDR, got);
        if (got !== ((8'hA5 ^ 8'hFF) & `PORTB_PIN_MASK))
            report_mismatch("gpio pin toggle", (8'hA5 ^ 8'hFF) & `PORTB_PIN_MASK, got);
        pb_in  = 8'h6B;
        waited = 0;
        io_read(`PORTB_PIN_ADDR, got);
        while (got !== (8'h6B & `PORTB_PIN_MASK) && waited < 4)
        begin
            io_read(`PORTB_PIN_ADDR, got);
            waited++;
        end
        if (got !== (8'h6B & `PORTB_PIN_MASK))
            report_mismatch("gpio pin read", 8'h6B & `PORTB_PIN_MASK, got);
        io_write(`PORTB_PORT_ADDR, 8'h00);
        io_write(`PORTB_DDR_ADDR, 8'h00);
    endtask

    task automatic overflow_irq();
        byte_t got;
        int    waited;
        data_write(`TIMSK0_ADDR, 8'h01);
        io_write(`TIFR0_ADDR, 8'h07);
        io_write(`TCCR0B_ADDR, {5'b0, CS_DIV1});
        io_write(`TCNT0_ADDR, 8'hF0);
        waited = 0;
        while (irq[`TIFR_TOV_BIT] !== 1'b1 && waited < 17 + 4)
        begin
            wait_cycles(1);
            waited++;
        end
        if (irq[`TIFR_TOV_BIT] !== 1'b1)
            log_error("overflow: irq did not rise within 21 cycles of TCNT0 = 0xF0");
        io_read(`TCNT0_ADDR, got);
        if (got >= 8'h10)
            log_error($sformatf("overflow: TCNT0 read %h after wrap, not below 10", got));
        irq_ack[`TIFR_TOV_BIT] = 1'b1;
        wait_cycles(1);
        irq_ack = 3'b000;
        if (irq[`TIFR_TOV_BIT] !== 1'b0)
            log_error("overflow: irq still high after irq_ack");
        io_write(`TCCR0B_ADDR, {5'b0, CS_STOP});
        data_write(`TIMSK0_ADDR, 8'h00);
        io_write(`TIFR0_ADDR, 8'h07);
    endtask

    task automatic ctc_toggle();
        byte_t n;
        byte_t got;
        int    toggles;
        int    window;
        logic  last;
        n = 8'd8 + (rand_byte() & 8'h1F);
        io_write(`TIFR0_ADDR, 8'h07);
        io_write(`OCR0A_ADDR, n);
        io_write(`TCNT0_ADDR, 8'h00);
        // COM0A toggle with WGM0 clear on compare
        io_write(`TCCR0A_ADDR, 8'h42);
        io_write(`TCCR0B_ADDR, {5'b0, CS_DIV1});
        if (oc0a_en !== 1'b1)
            log_error("ctc_toggle: oc0a_en low with COM0A set");
        window  = 10 * (int'(n) + 1);
        toggles = 0;
        last    = oc0a;
        repeat (window)
        begin
            wait_cycles(1);
            if (oc0a !== last)
                toggles++;
            last = oc0a;
        end
        if (toggles < 9 || toggles > 11)
            log_error($sformatf("ctc_toggle: %0d oc0a toggles in %0d cycles, OCR0A %0d",
                                toggles, window, n));
        // Start above OCR0A so the counter wraps through 0xFF
        io_write(`TCNT0_ADDR, 8'hF8);
        wait_cycles(12);
        io_read(`TIFR0_ADDR, got);
        if (got[`TIFR_TOV_BIT] !== 1'b0)
            report_mismatch("ctc_toggle TOV flag", 8'h00, {7'b0, got[`TIFR_TOV_BIT]});
        io_write(`TCCR0B_ADDR, {5'b0, CS_STOP});
        io_write(`TCCR0A_ADDR, 8'h00);
        io_write(`TIFR0_ADDR, 8'h07);
    endtask

    task automatic prescale_count();
        byte_t t0;
        byte_t t1;
        byte_t diff;
        io_write(`TCNT0_ADDR, 8'h00);
        io_write(`TCCR0B_ADDR, {5'b0, CS_DIV8});
        io_read(`TCNT0_ADDR, t0);
        wait_cycles(79);
        io_read(`TCNT0_ADDR, t1);
        diff = t1 - t0;
        if (diff < 8'd9 || diff > 8'd11)
            log_error($sformatf("prescale: TCNT0 moved %0d in 80 cycles at div8", diff));
        io_write(`TCCR0B_ADDR, {5'b0, CS_STOP});
        io_read(`TCNT0_ADDR, t0);
        wait_cycles(40);
        io_read(`TCNT0_ADDR, t1);
        if (t1 !== t0)
            report_mismatch("prescale stopped TCNT0", t0, t1);
        io_write(`TIFR0_ADDR, 8'h07);
    endtask

    task automatic flag_masking();
        byte_t got;
        int    waited;
        logic  irq_seen;
        data_write(`TIMSK0_ADDR, 8'h00);
        io_write(`TIFR0_ADDR, 8'h07);
        io_write(`TCNT0_ADDR, 8'h00);
        io_write(`OCR0B_ADDR, rand_byte());
        io_write(`TCCR0B_ADDR, {5'b0, CS_DIV1});
        got      = 8'h00;
        waited   = 0;
        irq_seen = 1'b0;
        while (got[`TIFR_OCFB_BIT] !== 1'b1 && waited < 300)
        begin
            io_read(`TIFR0_ADDR, got);
            if (irq[`TIFR_OCFB_BIT] !== 1'b0)
                irq_seen = 1'b1;
            waited++;
        end
        if (got[`TIFR_OCFB_BIT] !== 1'b1)
            log_error("flag_masking: OCF0B never set within 300 cycles");
        if (irq_seen)
            log_error("flag_masking: compare B irq rose while OCIE0B clear");
        io_write(`TCCR0B_ADDR, {5'b0, CS_STOP});
        io_write(`TIFR0_ADDR, 8'h04);
        io_read(`TIFR0_ADDR, got);
        if (got[`TIFR_OCFB_BIT] !== 1'b0)
            report_mismatch("flag_masking OCF0B clear", 8'h00, got & 8'h04);
        io_write(`TIFR0_ADDR, 8'h07);
    endtask

    initial
    begin
        rst        = 1'b1;
        io_addr    = '0;
        io_wr      = 1'b0;
        io_rd      = 1'b0;
        io_wdata   = '0;
        data_addr  = '0;
        data_wr    = 1'b0;
        data_rd    = 1'b0;
        data_wdata = '0;
        irq_ack    = '0;
        pb_in      = '0;
        errors     = 0;
        void'($urandom(SEED));
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_cycles(1);

        register_access();
        gpio_pins();
        overflow_irq();
        ctc_toggle();
        prescale_count();
        flag_masking();

        $display("Tests run: 6, errors: %0d", errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* verif/avr_periph_chk.sv */
/* Checks on the peripheral top level, sampled at the rising clk edge.
   Bound into every avr_periph_top instance. */
`timescale 1ns/1ps
`include "avr_periph_macros.svh"

module avr_periph_chk (
    input logic       clk,
    input logic       rst,
    input logic       io_rd,
    input logic [7:0] io_rdata,
    input logic       data_rd,
    input logic [7:0] data_rdata,
    input logic [2:0] irq,
    input logic       oc0a_en,
    input logic [7:0] pb_out,
    input logic [7:0] pb_oe
);

    // Outputs idle in the first cycle out of reset
    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> (irq == 3'b000) && (pb_oe == 8'h00) && !oc0a_en)
        else $error("irq, pb_oe or oc0a_en not zero after reset");

    // Idle read strobes give zero read data
    a_io_idle: assert property (@(posedge clk) !io_rd |-> (io_rdata == 8'h00))
        else $error("io_rdata nonzero while io_rd low");

    a_data_idle: assert property (@(posedge clk) !data_rd |-> (data_rdata == 8'h00))
        else $error("data_rdata nonzero while data_rd low");

    a_pb_mask: assert property (@(posedge clk) (pb_out & ~`PORTB_PIN_MASK) == 8'h00)
        else $error("pb_out drives a bit outside the port B pin mask");

endmodule

bind avr_periph_top avr_periph_chk i_avr_periph_chk (
    .clk        (clk),
    .rst        (rst),
    .io_rd      (io_rd),
    .io_rdata   (io_rdata),
    .data_rd    (data_rd),
    .data_rdata (data_rdata),
    .irq        (irq),
    .oc0a_en    (oc0a_en),
    .pb_out     (pb_out),
    .pb_oe      (pb_oe)
);

/* design/avr_periph_top.sv */
/* Peripheral block driven by an external bus master acting as the core.
   Reads are combinational and return zero for unmapped addresses or idle strobes. */
`timescale 1ns/1ps
`include "avr_periph_macros.svh"

module avr_periph_top (
    input  logic                         clk,
    input  logic                         rst,
    // I/O space
    input  avr_periph_pkg::io_addr_t     io_addr,
    input  logic                         io_wr,
    input  logic                         io_rd,
    input  avr_periph_pkg::byte_t        io_wdata,
    output avr_periph_pkg::byte_t        io_rdata,
    // Extended data space
    input  avr_periph_pkg::data_addr_t   data_addr,
    input  logic                         data_wr,
    input  logic                         data_rd,
    input  avr_periph_pkg::byte_t        data_wdata,
    output avr_periph_pkg::byte_t        data_rdata,
    // Timer 0 interrupts and compare output
    output avr_periph_pkg::irq_vec_t     irq,
    input  avr_periph_pkg::irq_vec_t     irq_ack,
    output logic                         oc0a,
    output logic                         oc0a_en,
    // Port B pads
    input  avr_periph_pkg::byte_t        pb_in,
    output avr_periph_pkg::byte_t        pb_out,
    output avr_periph_pkg::byte_t        pb_oe
);
    import avr_periph_pkg::*;

    logic  tick8;
    logic  tick64;
    logic  tick256;
    logic  tick1024;
    byte_t tim0_io_rdata;
    byte_t tim0_data_rdata;
    byte_t portb_io_rdata;

    tim_prescaler i_prescaler (
        .clk      (clk),
        .rst      (rst),
        .tick8    (tick8),
        .tick64   (tick64),
        .tick256  (tick256),
        .tick1024 (tick1024)
    );

    tim0_8bit i_tim0 (
        .clk        (clk),
        .rst        (rst),
        .tick8      (tick8),
        .tick64     (tick64),
        .tick256    (tick256),
        .tick1024   (tick1024),
        .io_addr    (io_addr),
        .io_wr      (io_wr),
        .io_rd      (io_rd),
        .io_wdata   (io_wdata),
        .io_rdata   (tim0_io_rdata),
        .data_addr  (data_addr),
        .data_wr    (data_wr),
        .data_rd    (data_rd),
        .data_wdata (data_wdata),
        .data_rdata (tim0_data_rdata),
        .irq        (irq),
        .irq_ack    (irq_ack),
        .oc0a       (oc0a),
        .oc0a_en    (oc0a_en)
    );

    gpio_port #(
        .PORT_ADDR (`PORTB_PORT_ADDR),
        .DDR_ADDR  (`PORTB_DDR_ADDR),
        .PIN_ADDR  (`PORTB_PIN_ADDR),
        .PIN_MASK  (`PORTB_PIN_MASK)
    ) i_portb (
        .clk      (clk),
        .rst      (rst),
        .io_addr  (io_addr),
        .io_wr    (io_wr),
        .io_rd    (io_rd),
        .io_wdata (io_wdata),
        .io_rdata (portb_io_rdata),
        .pad_in   (pb_in),
        .pad_out  (pb_out),
        .pad_oe   (pb_oe)
    );

    // Each peripheral returns zero unless addressed
    assign io_rdata   = tim0_io_rdata | portb_io_rdata;
    assign data_rdata = tim0_data_rdata;

endmodule

/* design/gpio_port.sv */
/* General-purpose port without pull-ups. Bits outside PIN_MASK read and drive zero;
   pad inputs pass a two-stage synchronizer, so PIN reads lag the pads by 2 cycles. */
`timescale 1ns/1ps
`include "avr_periph_macros.svh"

module gpio_port #(
    parameter avr_periph_pkg::io_addr_t PORT_ADDR = `PORTB_PORT_ADDR,
    parameter avr_periph_pkg::io_addr_t DDR_ADDR  = `PORTB_DDR_ADDR,
    parameter avr_periph_pkg::io_addr_t PIN_ADDR  = `PORTB_PIN_ADDR,
    parameter avr_periph_pkg::byte_t    PIN_MASK  = `PORTB_PIN_MASK
) (
    input  logic                     clk,
    input  logic                     rst,
    input  avr_periph_pkg::io_addr_t io_addr,
    input  logic                     io_wr,
    input  logic                     io_rd,
    input  avr_periph_pkg::byte_t    io_wdata,
    output avr_periph_pkg::byte_t    io_rdata,
    input  avr_periph_pkg::byte_t    pad_in,
    output avr_periph_pkg::byte_t    pad_out,
    output avr_periph_pkg::byte_t    pad_oe
);
    import avr_periph_pkg::*;

    byte_t port_q;
    byte_t ddr_q;
    byte_t pin_meta;
    byte_t pin_sync;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            port_q   <= '0;
            ddr_q    <= '0;
            pin_meta <= '0;
            pin_sync <= '0;
        end
        else
        begin
            // Writing 1s to PIN toggles the output latch
            if (io_wr && (io_addr == PORT_ADDR))
                port_q <= io_wdata & PIN_MASK;
            else if (io_wr && (io_addr == PIN_ADDR))
                port_q <= (port_q ^ io_wdata) & PIN_MASK;

            if (io_wr && (io_addr == DDR_ADDR))
                ddr_q <= io_wdata & PIN_MASK;

            pin_meta <= pad_in & PIN_MASK;
            pin_sync <= pin_meta;
        end
    end

    assign pad_out = port_q;
    assign pad_oe  = ddr_q;

    always_comb
    begin
        io_rdata = '0;
        if (io_rd)
        begin
            if (io_addr == PORT_ADDR)
                io_rdata = port_q;
            else if (io_addr == DDR_ADDR)
                io_rdata = ddr_q;
            else if (io_addr == PIN_ADDR)
                io_rdata = pin_sync;
        end
    end

endmodule

/* design/tim0_8bit.sv */
/* Timer 0, normal and CTC modes only; PWM modes and the OC0B pin are not built.
   Flags set one cycle after the matching count; set beats clear in the same cycle. */
`timescale 1ns/1ps
`include "avr_periph_macros.svh"

module tim0_8bit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         tick8,
    input  logic                         tick64,
    input  logic                         tick256,
    input  logic                         tick1024,
    input  avr_periph_pkg::io_addr_t     io_addr,
    input  logic                         io_wr,
    input  logic                         io_rd,
    input  avr_periph_pkg::byte_t        io_wdata,
    output avr_periph_pkg::byte_t        io_rdata,
    input  avr_periph_pkg::data_addr_t   data_addr,
    input  logic                         data_wr,
    input  logic                         data_rd,
    input  avr_periph_pkg::byte_t        data_wdata,
    output avr_periph_pkg::byte_t        data_rdata,
    output avr_periph_pkg::irq_vec_t     irq,
    input  avr_periph_pkg::irq_vec_t     irq_ack,
    output logic                         oc0a,
    output logic                         oc0a_en
);
    import avr_periph_pkg::*;

    byte_t      tccr0a_q;
    byte_t      tccr0b_q;
    byte_t      tcnt0_q;
    byte_t      ocr0a_q;
    byte_t      ocr0b_q;
    irq_vec_t   tifr0_q;
    irq_vec_t   timsk0_q;
    logic       oc0a_q;

    tim_cs_t    cs;
    logic [2:0] wgm;
    logic [1:0] com0a;
    logic       ctc_mode;
    logic       count_en;
    logic       tcnt0_wr;
    logic       tifr0_wr;
    logic       step;
    logic       match_a;
    logic       match_b;
    irq_vec_t   flag_set;
    irq_vec_t   flag_clr;

    assign cs       = tim_cs_t'(tccr0b_q[2:0]);
    assign wgm      = {tccr0b_q[3], tccr0a_q[1:0]};
    assign com0a    = tccr0a_q[7:6];
    assign ctc_mode = (wgm == `TIM0_WGM_CTC);

    assign tcnt0_wr = io_wr && (io_addr == `TCNT0_ADDR);
    assign tifr0_wr = io_wr && (io_addr == `TIFR0_ADDR);

    // Count enable from the clock select
    always_comb
    begin
        case (cs)
            CS_DIV1:    count_en = 1'b1;
            CS_DIV8:    count_en = tick8;
            CS_DIV64:   count_en = tick64;
            CS_DIV256:  count_en = tick256;
            CS_DIV1024: count_en = tick1024;
            default:    count_en = 1'b0;
        endcase
    end

    // A TCNT0 write blocks counting and matching for that cycle
    assign step    = count_en && !tcnt0_wr;
    assign match_a = (tcnt0_q == ocr0a_q);
    assign match_b = (tcnt0_q == ocr0b_q);

    always_comb
    begin
        flag_set                 = '0;
        flag_set[`TIFR_TOV_BIT]  = step && !ctc_mode && (tcnt0_q == 8'hFF);
        flag_set[`TIFR_OCFA_BIT] = step && match_a;
        flag_set[`TIFR_OCFB_BIT] = step && match_b;
    end

    // Write-one-to-clear, or acknowledge from the core
    assign flag_clr = irq_ack | (tifr0_wr ? io_wdata[2:0] : 3'b000);

    // Control and compare registers
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tccr0a_q <= '0;
            tccr0b_q <= '0;
            ocr0a_q  <= '0;
            ocr0b_q  <= '0;
            timsk0_q <= '0;
        end
        else
        begin
            if (io_wr && (io_addr == `TCCR0A_ADDR))
                tccr0a_q <= io_wdata & `TCCR0A_WMASK;
            if (io_wr && (io_addr == `TCCR0B_ADDR))
                tccr0b_q <= io_wdata & `TCCR0B_WMASK;
            if (io_wr && (io_addr == `OCR0A_ADDR))
                ocr0a_q <= io_wdata;
            if (io_wr && (io_addr == `OCR0B_ADDR))
                ocr0b_q <= io_wdata;
            if (data_wr && (data_addr == `TIMSK0_ADDR))
                timsk0_q <= data_wdata[2:0];
        end
    end

    // Counter, flags and compare A output
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tcnt0_q <= '0;
            tifr0_q <= '0;
            oc0a_q  <= 1'b0;
        end
        else
        begin
            if (tcnt0_wr)
                tcnt0_q <= io_wdata;
            else if (step && ctc_mode && match_a)
                tcnt0_q <= '0;
            else if (step)
                tcnt0_q <= tcnt0_q + 8'd1;

            tifr0_q <= flag_set | (tifr0_q & ~flag_clr);

            if (flag_set[`TIFR_OCFA_BIT] && (com0a == `TIM0_COM_TOGGLE))
                oc0a_q <= ~oc0a_q;
        end
    end

    assign irq     = tifr0_q & timsk0_q;
    assign oc0a    = oc0a_q;
    assign oc0a_en = |com0a;

    // Read data, zero unless one of our addresses is read
    always_comb
    begin
        io_rdata = '0;
        if (io_rd)
        begin
            case (io_addr)
                `TIFR0_ADDR:  io_rdata = {5'b0, tifr0_q};
                `TCCR0A_ADDR: io_rdata = tccr0a_q;
                `TCCR0B_ADDR: io_rdata = tccr0b_q;
                `TCNT0_ADDR:  io_rdata = tcnt0_q;
                `OCR0A_ADDR:  io_rdata = ocr0a_q;
                `OCR0B_ADDR:  io_rdata = ocr0b_q;
                default:      io_rdata = '0;
            endcase
        end
    end

    assign data_rdata = (data_rd && (data_addr == `TIMSK0_ADDR)) ? {5'b0, timsk0_q} : 8'h00;

endmodule

/* design/tim_prescaler.sv */
/* Shared timer prescaler. Ticks are one clk wide and phase-locked to reset;
   the first tick8 comes 8 cycles after rst is released. */
`timescale 1ns/1ps
`include "avr_periph_macros.svh"

module tim_prescaler (
    input  logic clk,
    input  logic rst,
    output logic tick8,
    output logic tick64,
    output logic tick256,
    output logic tick1024
);

    logic [`PRESCALE_CNT_W-1:0] cnt;

    // Free-running divider
    always_ff @(posedge clk)
    begin
        if (rst)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // One tick per wrap of the low bits
    assign tick8    = &cnt[`DIV8_LSBS-1:0];
    assign tick64   = &cnt[`DIV64_LSBS-1:0];
    assign tick256  = &cnt[`DIV256_LSBS-1:0];
    assign tick1024 = &cnt[`DIV1024_LSBS-1:0];

endmodule

/* design/avr_periph_pkg.sv */
/* Types shared by the peripheral RTL.
   Clock select codes 6 and 7 are not named and behave as stopped. */
package avr_periph_pkg;

    // Bus words
    typedef logic [5:0] io_addr_t;
    typedef logic [7:0] data_addr_t;
    typedef logic [7:0] byte_t;

    // Timer clock select, CS02:0
    typedef enum logic [2:0] {
        CS_STOP    = 3'd0,
        CS_DIV1    = 3'd1,
        CS_DIV8    = 3'd2,
        CS_DIV64   = 3'd3,
        CS_DIV256  = 3'd4,
        CS_DIV1024 = 3'd5
    } tim_cs_t;

    // Timer 0 interrupt lines, bit 0 overflow, bit 1 compare A, bit 2 compare B
    typedef logic [2:0] irq_vec_t;

endpackage

/* design/avr_periph_macros.svh */
/* Register map and constants for the peripheral block.
   Only the bits covered by the write masks are stored; all other bits read zero. */
`ifndef AVR_PERIPH_MACROS_SVH
`define AVR_PERIPH_MACROS_SVH

// Port B, I/O space
`define PORTB_PIN_ADDR      6'h03
`define PORTB_DDR_ADDR      6'h04
`define PORTB_PORT_ADDR     6'h05
`define PORTB_PIN_MASK      8'hF0

// Timer 0, I/O space
`define TIFR0_ADDR          6'h15
`define TCCR0A_ADDR         6'h24
`define TCCR0B_ADDR         6'h25
`define TCNT0_ADDR          6'h26
`define OCR0A_ADDR          6'h27
`define OCR0B_ADDR          6'h28

// Timer 0, extended data space
`define TIMSK0_ADDR         8'h6E

// Flag and mask positions, shared by TIFR0, TIMSK0 and irq
`define TIFR_TOV_BIT        0
`define TIFR_OCFA_BIT       1
`define TIFR_OCFB_BIT       2

// Stored control bits: COM0A and WGM01:0, then WGM02 and CS02:0
`define TCCR0A_WMASK        8'hC3
`define TCCR0B_WMASK        8'h0F
`define TIM0_WGM_CTC        3'b010
`define TIM0_COM_TOGGLE     2'b01

// Prescaler divider width and the low bits that set each tick
`define PRESCALE_CNT_W      10
`define DIV8_LSBS           3
`define DIV64_LSBS          6
`define DIV256_LSBS         8
`define DIV1024_LSBS        10

`endif
